// File: tb.f
source/arch_pkg.sv
source/rob_pkg.sv
source/rob_map_if.sv
source/map_table.sv
source/reorder_buffer.sv
source/rename_core.sv
verification/rename_tb.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module rename_tb -f tb.f

sim:
	verilator --binary --timing -j 0 --top-module rename_tb -Mdir obj_dir -f tb.f
	./obj_dir/Vrename_tb

clean:
	rm -rf obj_dir

// File: verification/rename_tb.sv
// rename core testbench with clock, reset, random stimulus, reference model and checks
`timescale 1ns/100ps
`default_nettype none

module rename_tb import arch_pkg::*, rob_pkg::*; ();

    localparam int rob_size = 8;

    logic        clock;
    logic        reset;
    logic        dispatch_valid, dest_valid, rs1_valid, rs2_valid, branch_valid;
    arch_reg_idx dest, rs1, rs2, retire_dest;
    rob_tag      cdb_tag, branch_tag, dispatch_tag, rs1_tag, rs2_tag, retire_tag;
    logic        dispatch_ready, rs1_ready, rs2_ready, retire_valid, retire_dest_valid;

    // expected DUT outputs for one cycle
    typedef struct packed {
        logic        dispatch_ready;
        rob_tag      dispatch_tag;
        rob_tag      rs1_tag;
        logic        rs1_ready;
        rob_tag      rs2_tag;
        logic        rs2_ready;
        logic        retire_valid;
        rob_tag      retire_tag;
        logic        retire_dest_valid;
        arch_reg_idx retire_dest;
    } rename_outputs;

    // reference map table and circular buffer
    rob_tag      m_tag    [32];
    logic        m_ready  [32];
    logic        m_done   [1:rob_size];
    logic        m_dvalid [1:rob_size];
    arch_reg_idx m_dest   [1:rob_size];
    rob_tag      m_head;
    rob_tag      m_tail;
    int          m_count;
    logic        checking = 1'b0;
    int unsigned lcg_state = 47204;

    rename_core #(.rob_size(rob_size)) i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic int unsigned next_random(input int unsigned range);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) % range;
    endfunction

    // tags wrap from rob_size back to 1
    function automatic rob_tag wrap_next(input rob_tag t);
        return (t == rob_tag'(rob_size)) ? rob_tag'(1) : t + rob_tag'(1);
    endfunction

    // tag sitting pos places behind the head
    function automatic rob_tag tag_at(input int pos);
        return rob_tag'((int'(m_head) - 1 + pos) % rob_size + 1);
    endfunction

    function automatic int position_of(input rob_tag t);
        return (int'(t) - int'(m_head) + rob_size) % rob_size;
    endfunction

    // expected outputs from the reference state and the applied inputs
    function automatic rename_outputs expected_outputs();
        rename_outputs e;
        e = '0;
        e.dispatch_ready = (m_count != rob_size);
        e.dispatch_tag   = m_tail;
        if (rs1_valid) begin
            e.rs1_tag   = m_tag[rs1];
            e.rs1_ready = m_ready[rs1];
        end
        if (rs2_valid) begin
            e.rs2_tag   = m_tag[rs2];
            e.rs2_ready = m_ready[rs2];
        end
        e.retire_valid      = (m_count != 0) && m_done[m_head];
        e.retire_tag        = m_head;
        e.retire_dest_valid = e.retire_valid && m_dvalid[m_head];
        e.retire_dest       = m_dest[m_head];
        return e;
    endfunction

    task automatic reset_model();
        for (int r = 0; r < 32; r++) begin
            m_tag[r]   = '0;
            m_ready[r] = 1'b0;
        end
        for (int t = 1; t <= rob_size; t++) begin
            m_done[t]   = 1'b0;
            m_dvalid[t] = 1'b0;
            m_dest[t]   = '0;
        end
        m_head  = rob_tag'(1);
        m_tail  = rob_tag'(1);
        m_count = 0;
    endtask

    // one rising edge of the reference
    task automatic advance_model();
        logic retire;
        logic accept;
        logic squashed [0:31];
        int   branch_pos;
        retire     = (m_count != 0) && m_done[m_head];
        accept     = dispatch_valid && (m_count != rob_size) && !branch_valid;
        branch_pos = position_of(branch_tag);
        for (int t = 0; t < 32; t++) begin
            squashed[t] = 1'b0;
        end
        if (branch_valid) begin
            for (int p = branch_pos + 1; p < m_count; p++) begin
                squashed[tag_at(p)] = 1'b1;
            end
        end
        // a clear beats a ready set, a new rename beats both
        for (int r = 0; r < 32; r++) begin
            if (cdb_tag != '0 && m_tag[r] == cdb_tag) begin
                m_ready[r] = 1'b1;
            end
            if (m_tag[r] != '0 && (squashed[m_tag[r]] || (retire && m_tag[r] == m_head))) begin
                m_tag[r]   = '0;
                m_ready[r] = 1'b0;
            end
        end
        if (accept && dest_valid && dest != zero_reg) begin
            m_tag[dest]   = m_tail;
            m_ready[dest] = 1'b0;
        end
        // buffer entries and pointers
        if (cdb_tag != '0 && !squashed[cdb_tag]) begin
            m_done[cdb_tag] = 1'b1;
        end
        if (accept) begin
            m_done[m_tail]   = 1'b0;
            m_dvalid[m_tail] = dest_valid;
            m_dest[m_tail]   = dest;
            m_tail           = wrap_next(m_tail);
            m_count++;
        end
        if (retire) begin
            m_head = wrap_next(m_head);
            m_count--;
        end
        if (branch_valid) begin
            m_tail  = wrap_next(branch_tag);
            m_count = branch_pos + 1 - int'(retire);
        end
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            stop_with_failure($sformatf("[FAIL] %0d ns: %s is %0d, expected %0d",
                $time, name, got, exp));
        end
    endtask

    // compare shortly before each rising edge
    initial begin
        rename_outputs e;
        forever begin
            @(negedge clock);
            #8;
            if (checking) begin
                e = expected_outputs();
                check_field("dispatch_ready", 32'(dispatch_ready), 32'(e.dispatch_ready));
                check_field("dispatch_tag", 32'(dispatch_tag), 32'(e.dispatch_tag));
                check_field("rs1_tag", 32'(rs1_tag), 32'(e.rs1_tag));
                check_field("rs1_ready", 32'(rs1_ready), 32'(e.rs1_ready));
                check_field("rs2_tag", 32'(rs2_tag), 32'(e.rs2_tag));
                check_field("rs2_ready", 32'(rs2_ready), 32'(e.rs2_ready));
                check_field("retire_valid", 32'(retire_valid), 32'(e.retire_valid));
                check_field("retire_dest_valid", 32'(retire_dest_valid),
                            32'(e.retire_dest_valid));
                if (e.retire_valid) begin
                    check_field("retire_tag", 32'(retire_tag), 32'(e.retire_tag));
                end
                if (e.retire_dest_valid) begin
                    check_field("retire_dest", 32'(retire_dest), 32'(e.retire_dest));
                end
            end
        end
    end

    // inputs change on the falling edge, the reference follows the rising edge
    task automatic drive_cycle(input logic dv, input logic dstv, input arch_reg_idx d,
                               input logic r1v, input arch_reg_idx r1,
                               input logic r2v, input arch_reg_idx r2,
                               input rob_tag cdb, input logic bv, input rob_tag bt);
        @(negedge clock);
        dispatch_valid = dv;
        dest_valid     = dstv;
        dest           = d;
        rs1_valid      = r1v;
        rs1            = r1;
        rs2_valid      = r2v;
        rs2            = r2;
        cdb_tag        = cdb;
        branch_valid   = bv;
        branch_tag     = bt;
        @(posedge clock);
        advance_model();
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0, '0, 1'b0, '0);
    endtask

    // the destination is also looked up, which must still show the old mapping
    task automatic dispatch(input logic dstv, input arch_reg_idx d);
        drive_cycle(1'b1, dstv, d, 1'b1, d, 1'b0, '0, '0, 1'b0, '0);
    endtask

    // registers 5 and 6 are watched while results arrive and entries retire
    task automatic complete(input rob_tag t);
        drive_cycle(1'b0, 1'b0, '0, 1'b1, arch_reg_idx'(5), 1'b1, arch_reg_idx'(6),
                    t, 1'b0, '0);
    endtask

    // dispatch held high in the squash cycle
    task automatic squash(input rob_tag t);
        drive_cycle(1'b1, 1'b1, arch_reg_idx'(20), 1'b0, '0, 1'b0, '0, '0, 1'b1, t);
    endtask

    task automatic scan_map();
        for (int i = 0; i < 16; i++) begin
            drive_cycle(1'b0, 1'b0, '0, 1'b1, arch_reg_idx'(2 * i),
                        1'b1, arch_reg_idx'(2 * i + 1), '0, 1'b0, '0);
        end
    endtask

    task automatic wait_for_retire(input rob_tag t);
        int waited;
        waited = 0;
        #1;
        while (!(retire_valid && retire_tag == t)) begin
            if (waited == 20) begin
                stop_with_failure($sformatf("timed out waiting for tag %0d to retire", t));
            end
            idle_cycle();
            #1;
            waited++;
        end
        idle_cycle();
    endtask

    task automatic fill_buffer();
        int waited;
        waited = 0;
        #1;
        while (dispatch_ready) begin
            if (waited == rob_size + 1) begin
                stop_with_failure("the reorder buffer never reported full");
            end
            dispatch(1'b1, arch_reg_idx'(8 + waited));
            #1;
            waited++;
        end
    endtask

    task automatic random_cycle();
        logic   bv;
        rob_tag cdb;
        rob_tag bt;
        cdb = '0;
        bv  = 1'b0;
        bt  = '0;
        if (m_count != 0 && next_random(2) == 0) begin
            cdb = tag_at(int'(next_random(m_count)));
        end
        // rare branch on a live tag
        if (m_count != 0 && next_random(16) == 0) begin
            bv = 1'b1;
            bt = tag_at(int'(next_random(m_count)));
        end
        drive_cycle(next_random(10) < 6, next_random(8) != 0, arch_reg_idx'(next_random(32)),
                    next_random(4) != 0, arch_reg_idx'(next_random(32)),
                    next_random(4) != 0, arch_reg_idx'(next_random(32)), cdb, bv, bt);
    endtask

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dest_valid     = 1'b0;
        dest           = '0;
        rs1_valid      = 1'b0;
        rs1            = '0;
        rs2_valid      = 1'b0;
        rs2            = '0;
        cdb_tag        = '0;
        branch_valid   = 1'b0;
        branch_tag     = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        reset_model();
        checking = 1'b1;
        scan_map();

        // renames, with x0 and a dispatch without destination
        dispatch(1'b1, arch_reg_idx'(5));
        dispatch(1'b1, arch_reg_idx'(6));
        dispatch(1'b1, zero_reg);
        dispatch(1'b0, arch_reg_idx'(7));
        dispatch(1'b1, arch_reg_idx'(5));
        scan_map();

        // out of order completion, in order retirement
        complete(rob_tag'(2));
        complete(rob_tag'(1));
        complete(rob_tag'(3));
        complete(rob_tag'(5));
        complete(rob_tag'(4));
        wait_for_retire(rob_tag'(5));
        scan_map();

        // full buffer ignores dispatch, then a squash across the wrap
        fill_buffer();
        dispatch(1'b1, arch_reg_idx'(30));
        dispatch(1'b1, arch_reg_idx'(31));
        squash(tag_at(1));
        dispatch(1'b1, arch_reg_idx'(12));
        scan_map();

        for (int i = 0; i < 2000; i++) begin
            random_cycle();
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/rename_core.sv
// register-renaming top level joining the reorder buffer and the map table
`timescale 1ns/100ps
`default_nettype none

module rename_core import arch_pkg::*, rob_pkg::*; #(
    parameter int rob_size = 8
) (
    input  logic        clock,
    input  logic        reset,

    // dispatch
    input  logic        dispatch_valid,
    input  logic        dest_valid,
    input  arch_reg_idx dest,
    input  logic        rs1_valid,
    input  arch_reg_idx rs1,
    input  logic        rs2_valid,
    input  arch_reg_idx rs2,

    // completion and branch resolution
    input  rob_tag      cdb_tag,
    input  logic        branch_valid,
    input  rob_tag      branch_tag,

    output logic        dispatch_ready,
    output rob_tag      dispatch_tag,
    output rob_tag      rs1_tag,
    output logic        rs1_ready,
    output rob_tag      rs2_tag,
    output logic        rs2_ready,

    // retirement
    output logic        retire_valid,
    output rob_tag      retire_tag,
    output logic        retire_dest_valid,
    output arch_reg_idx retire_dest
);

    rob_map_if i_rob_map ();

    reorder_buffer #(
        .rob_size (rob_size)
    ) i_rob (
        .clock             (clock),
        .reset             (reset),
        .map               (i_rob_map.rob),
        .dispatch_valid    (dispatch_valid),
        .dest_valid        (dest_valid),
        .dest              (dest),
        .cdb_tag           (cdb_tag),
        .branch_valid      (branch_valid),
        .branch_tag        (branch_tag),
        .dispatch_ready    (dispatch_ready),
        .dispatch_tag      (dispatch_tag),
        .retire_dest_valid (retire_dest_valid),
        .retire_dest       (retire_dest)
    );

    map_table i_map (
        .clock      (clock),
        .reset      (reset),
        .rob        (i_rob_map.map),
        .cdb_tag    (cdb_tag),
        .dest_valid (dest_valid),
        .dest       (dest),
        .rs1_valid  (rs1_valid),
        .rs1        (rs1),
        .rs2_valid  (rs2_valid),
        .rs2        (rs2),
        .rs1_tag    (rs1_tag),
        .rs1_ready  (rs1_ready),
        .rs2_tag    (rs2_tag),
        .rs2_ready  (rs2_ready)
    );

    // retire pulse and head tag as seen by the map table
    assign retire_valid = i_rob_map.retire_valid;
    assign retire_tag   = i_rob_map.retire_tag;

endmodule

`default_nettype wire

// File: source/reorder_buffer.sv
// reorder buffer for tag allocation, completion marking, in-order retire and branch squash
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer import arch_pkg::*, rob_pkg::*; #(
    parameter int rob_size = 8
) (
    input  logic        clock,
    input  logic        reset,

    // allocation, retire and squash news for the map table
    rob_map_if.rob      map,

    // dispatch request
    input  logic        dispatch_valid,
    input  logic        dest_valid,
    input  arch_reg_idx dest,

    // completion broadcast, 0 when idle
    input  rob_tag      cdb_tag,

    // mispredicted branch
    input  logic        branch_valid,
    input  rob_tag      branch_tag,

    output logic        dispatch_ready,
    output rob_tag      dispatch_tag,
    output logic        retire_dest_valid,
    output arch_reg_idx retire_dest
);

    // per-entry state, indexed directly by tag
    logic        done_q       [1:rob_size];
    logic        dest_valid_q [1:rob_size];
    arch_reg_idx dest_q       [1:rob_size];

    // oldest live tag, next tag to hand out, and number of live entries
    rob_tag head_q;
    rob_tag tail_q;
    rob_tag count_q;

    logic   accept;
    logic   retire;
    logic   cdb_hit;
    rob_tag branch_age;
    rob_mask squash_mask;

    // tag after t, wrapping from rob_size back to 1
    function automatic rob_tag next_tag(input rob_tag t);
        if (t == rob_tag'(rob_size)) begin
            return rob_tag'(1);
        end
        return t + rob_tag'(1);
    endfunction

    // position of tag t behind the head, 0 for the head itself
    function automatic rob_tag age_of(input rob_tag t, input rob_tag h);
        int diff;
        diff = int'(t) - int'(h);
        if (diff < 0) begin
            diff = diff + rob_size;
        end
        return rob_tag'(diff);
    endfunction

    assign dispatch_ready = (count_q != rob_tag'(rob_size));
    assign dispatch_tag   = tail_q;

    // no allocation while a squash rewinds the tail
    assign accept = dispatch_valid && dispatch_ready && !branch_valid;

    // head leaves as soon as its result has been seen
    assign retire = (count_q != '0) && done_q[head_q];

    assign branch_age = age_of(branch_tag, head_q);

    // live tags behind the branch, across the wrap if needed
    always_comb begin
        squash_mask = '0;
        for (int t = 1; t <= rob_size; t++) begin
            if (branch_valid
                && (age_of(rob_tag'(t), head_q) > branch_age)
                && (age_of(rob_tag'(t), head_q) < count_q)) begin
                squash_mask[t] = 1'b1;
            end
        end
    end

    // a squashed entry completing in the squash cycle is dropped
    assign cdb_hit = (cdb_tag != no_tag)
                  && (cdb_tag <= rob_tag'(rob_size))
                  && !squash_mask[cdb_tag];

    // pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= rob_tag'(1);
            tail_q  <= rob_tag'(1);
            count_q <= '0;
        end else begin
            if (retire) begin
                head_q <= next_tag(head_q);
            end
            if (branch_valid) begin
                tail_q  <= next_tag(branch_tag);
                count_q <= branch_age + rob_tag'(1) - rob_tag'(retire);
            end else begin
                if (accept) begin
                    tail_q <= next_tag(tail_q);
                end
                count_q <= count_q + rob_tag'(accept) - rob_tag'(retire);
            end
        end
    end

    // done flags
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int t = 1; t <= rob_size; t++) begin
                done_q[t] <= 1'b0;
            end
        end else begin
            if (cdb_hit) begin
                done_q[cdb_tag] <= 1'b1;
            end
            if (accept) begin
                done_q[tail_q] <= 1'b0;
            end
        end
    end

    // destination payload written at allocation
    always_ff @(posedge clock) begin
        if (accept) begin
            dest_valid_q[tail_q] <= dest_valid;
            dest_q[tail_q]       <= dest;
        end
    end

    assign retire_dest_valid = retire && dest_valid_q[head_q];
    assign retire_dest       = dest_q[head_q];

    // news for the map table
    assign map.alloc_valid  = accept;
    assign map.alloc_tag    = tail_q;
    assign map.retire_valid = retire;
    assign map.retire_tag   = head_q;
    assign map.squash_mask  = squash_mask;

endmodule

`default_nettype wire

// File: source/map_table.sv
// register map table holding tag and ready state per register, with two source lookups
`timescale 1ns/100ps
`default_nettype none

module map_table import arch_pkg::*, rob_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    // news from the reorder buffer
    rob_map_if.map      rob,

    // common data bus, 0 when idle
    input  rob_tag      cdb_tag,

    // destination of the instruction being dispatched
    input  logic        dest_valid,
    input  arch_reg_idx dest,

    // source operands of the instruction being dispatched
    input  logic        rs1_valid,
    input  arch_reg_idx rs1,
    input  logic        rs2_valid,
    input  arch_reg_idx rs2,

    // lookup results
    output rob_tag      rs1_tag,
    output logic        rs1_ready,
    output rob_tag      rs2_tag,
    output logic        rs2_ready
);

    // tag of the producing instruction plus a flag saying its value sits in the buffer
    typedef struct packed {
        rob_tag tag;
        logic   ready;
    } map_entry;

    map_entry map_q    [num_arch_regs];
    map_entry map_next [num_arch_regs];

    logic write_dest;

    // an entry is dropped when its producer retires or gets squashed
    function automatic logic clear_hit(input rob_tag tag);
        logic retire_hit;
        logic squash_hit;
        retire_hit = rob.retire_valid && (tag == rob.retire_tag);
        squash_hit = rob.squash_mask[tag];
        return (tag != no_tag) && (retire_hit || squash_hit);
    endfunction

    // only accepted dispatches reach here, x0 keeps no mapping
    assign write_dest = rob.alloc_valid && dest_valid && (dest != zero_reg);

    // next state, lowest priority first so later writes win
    always_comb begin
        for (int i = 0; i < num_arch_regs; i++) begin
            map_next[i] = map_q[i];

            // completion broadcast
            if ((cdb_tag != no_tag) && (map_q[i].tag == cdb_tag)) begin
                map_next[i].ready = 1'b1;
            end

            // retire or squash of the producer
            if (clear_hit(map_q[i].tag)) begin
                map_next[i].tag   = no_tag;
                map_next[i].ready = 1'b0;
            end
        end

        // new producer for the destination beats everything else
        if (write_dest) begin
            map_next[dest].tag   = rob.alloc_tag;
            map_next[dest].ready = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_arch_regs; i++) begin
                map_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_arch_regs; i++) begin
                map_q[i] <= map_next[i];
            end
        end
    end

    // lookups see the registered state, a same-cycle dispatch is not forwarded
    always_comb begin
        if (rs1_valid) begin
            rs1_tag   = map_q[rs1].tag;
            rs1_ready = map_q[rs1].ready;
        end else begin
            rs1_tag   = no_tag;
            rs1_ready = 1'b0;
        end
    end

    always_comb begin
        if (rs2_valid) begin
            rs2_tag   = map_q[rs2].tag;
            rs2_ready = map_q[rs2].ready;
        end else begin
            rs2_tag   = no_tag;
            rs2_ready = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/rob_map_if.sv
// interface from the reorder buffer to the map table for allocation, retire and squash
`timescale 1ns/100ps
`default_nettype none

interface rob_map_if import rob_pkg::*; ();

    // pulse for an accepted dispatch, with its new tag
    logic    alloc_valid;
    rob_tag  alloc_tag;

    // pulse while the head entry leaves the buffer
    logic    retire_valid;
    rob_tag  retire_tag;

    // tags younger than a mispredicted branch
    rob_mask squash_mask;

    // reorder buffer side
    modport rob (
        output alloc_valid,
        output alloc_tag,
        output retire_valid,
        output retire_tag,
        output squash_mask
    );

    // map table side
    modport map (
        input alloc_valid,
        input alloc_tag,
        input retire_valid,
        input retire_tag,
        input squash_mask
    );

endinterface

`default_nettype wire

// File: source/rob_pkg.sv
// reorder-buffer tag and mask types, the no-tag value and the size limit
`default_nettype none

package rob_pkg;

    // largest number of entries the buffer may be built with
    localparam int max_rob_size = 31;

    // tag 0 is reserved, valid tags run from 1 up to the buffer size
    typedef logic [$clog2(max_rob_size + 1)-1:0] rob_tag;

    // one bit per tag value, bit n set means tag n is being discarded
    typedef logic [max_rob_size:0] rob_mask;

    // tag value meaning the register file holds the value
    localparam rob_tag no_tag = '0;

endpackage

`default_nettype wire

// File: source/arch_pkg.sv
// architectural register index type, register count and zero-register constant
`default_nettype none

package arch_pkg;

    // number of integer registers in the architecture
    localparam int num_arch_regs = 32;

    // architectural register number
    typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_idx;

    // x0 reads as zero and is never renamed
    localparam arch_reg_idx zero_reg = '0;

endpackage

`default_nettype wire
